// ==== all.f ====
+incdir+dv
hdl/dma_pkg.sv
hdl/dsc_bypass.sv
hdl/dma_chan_stats.sv
hdl/dma_stat_regs.sv
hdl/dma_bypass_top.sv
dv/tb_clk_gen.sv
dv/dma_bypass_tb.sv

// ==== dv/dma_bypass_tb_table.svh ====
// DMA bypass testbench table
// Rows of operations with operands, ready level and expected register values.
// columns: op, arg (length or beat count), reg addr, ready, stall cycles, expected
// a ready of 0 stalls the bypass for the stall cycles, or the first beat once

localparam int N_ROWS = 39;

row_t rows [N_ROWS];

task automatic fill_table();
  rows[0]  = '{OP_REG_RD,    32'd0,         REG_WR_CMDS,   1'b1, 0, 32'd0};  // after reset
  rows[1]  = '{OP_REG_RD,    32'd0,         REG_FLUSHED,   1'b1, 0, 32'd1};  // 0 cmds, 0 pkgs
  rows[2]  = '{OP_WR_CMD,    32'h0000_0100, 4'd0,          1'b1, 0, 32'd0};
  rows[3]  = '{OP_WR_CMD,    32'hffff_fff0, 4'd0,          1'b1, 0, 32'd0};
  rows[4]  = '{OP_WR_CMD,    32'hffff_fff0, 4'd0,          1'b0, 3, 32'd0};  // c2h stalled
  rows[5]  = '{OP_RD_CMD,    32'h0000_0040, 4'd0,          1'b1, 0, 32'd0};
  rows[6]  = '{OP_RD_CMD,    32'h0000_0080, 4'd0,          1'b0, 4, 32'd0};  // h2c stalled
  rows[7]  = '{OP_C2H_BEATS, 32'd3,         4'd0,          1'b1, 0, 32'd0};
  rows[8]  = '{OP_C2H_BEATS, 32'd2,         4'd0,          1'b0, 0, 32'd0};  // first beat stalls
  rows[9]  = '{OP_H2C_BEATS, 32'd4,         4'd0,          1'b0, 0, 32'd0};
  rows[10] = '{OP_REG_RD,    32'd0,         REG_FLUSHED,   1'b1, 0, 32'd0};  // 2 cmds, 1 pkg
  rows[11] = '{OP_H2C_BEATS, 32'd1,         4'd0,          1'b1, 0, 32'd0};
  rows[12] = '{OP_REG_RD,    32'd0,         REG_WR_CMDS,   1'b1, 0, 32'd3};
  rows[13] = '{OP_REG_RD,    32'd0,         REG_WR_LEN_LO, 1'b1, 0, 32'h0000_00e0};
  rows[14] = '{OP_REG_RD,    32'd0,         REG_WR_LEN_HI, 1'b1, 0, 32'd2};  // sum 0x2_0000_00e0
  rows[15] = '{OP_REG_RD,    32'd0,         REG_WR_WORDS,  1'b1, 0, 32'd5};
  rows[16] = '{OP_REG_RD,    32'd0,         REG_WR_PKGS,   1'b1, 0, 32'd2};
  rows[17] = '{OP_REG_RD,    32'd0,         REG_RD_CMDS,   1'b1, 0, 32'd2};
  rows[18] = '{OP_REG_RD,    32'd0,         REG_RD_LEN_LO, 1'b1, 0, 32'h0000_00c0};
  rows[19] = '{OP_REG_RD,    32'd0,         REG_RD_LEN_HI, 1'b1, 0, 32'd0};
  rows[20] = '{OP_REG_RD,    32'd0,         REG_RD_WORDS,  1'b1, 0, 32'd5};
  rows[21] = '{OP_REG_RD,    32'd0,         REG_RD_PKGS,   1'b1, 0, 32'd2};
  rows[22] = '{OP_REG_RD,    32'd0,         REG_FLUSHED,   1'b1, 0, 32'd1};
  rows[23] = '{OP_REG_CLR,   32'd0,         REG_WR_LEN_LO, 1'b1, 0, 32'd0};
  rows[24] = '{OP_REG_RD,    32'd0,         REG_WR_LEN_LO, 1'b1, 0, 32'd0};
  rows[25] = '{OP_REG_RD,    32'd0,         REG_WR_LEN_HI, 1'b1, 0, 32'd0};
  rows[26] = '{OP_REG_RD,    32'd0,         REG_WR_CMDS,   1'b1, 0, 32'd3};  // count kept
  rows[27] = '{OP_REG_RD,    32'd0,         REG_RD_LEN_LO, 1'b1, 0, 32'h0000_00c0};
  rows[28] = '{OP_REG_RD,    32'd0,         REG_RD_CMDS,   1'b1, 0, 32'd2};
  rows[29] = '{OP_WR_CMD,    32'h0000_0020, 4'd0,          1'b1, 0, 32'd0};
  rows[30] = '{OP_REG_RD,    32'd0,         REG_WR_LEN_LO, 1'b1, 0, 32'h0000_0020};
  rows[31] = '{OP_RD_CMD,    32'h0000_0010, 4'd0,          1'b1, 0, 32'd0};
  rows[32] = '{OP_REG_RD,    32'd0,         REG_RD_CMDS,   1'b1, 0, 32'd3};
  rows[33] = '{OP_REG_RD,    32'd0,         REG_FLUSHED,   1'b1, 0, 32'd0};  // extra read cmd
  rows[34] = '{OP_REG_RD,    32'd0,         4'd15,         1'b1, 0, 32'd0};  // unmapped
  rows[35] = '{OP_REG_CLR,   32'd0,         REG_RD_LEN_LO, 1'b1, 0, 32'd0};
  rows[36] = '{OP_REG_RD,    32'd0,         REG_RD_LEN_LO, 1'b1, 0, 32'd0};
  rows[37] = '{OP_REG_RD,    32'd0,         REG_WR_LEN_LO, 1'b1, 0, 32'h0000_0020};
  rows[38] = '{OP_REG_RD,    32'd0,         REG_RD_CMDS,   1'b1, 0, 32'd3};
endtask

// ==== dv/dma_bypass_tb.sv ====
// DMA bypass front end testbench
// Applies a table of commands, stream bursts and register accesses to the
// DUT in a loop, checks descriptors, pass-through and counters, and reports.
`default_nettype none

module dma_bypass_tb import dma_pkg::*; ();

  typedef enum logic [2:0] {
    OP_WR_CMD, OP_RD_CMD, OP_C2H_BEATS, OP_H2C_BEATS, OP_REG_CLR, OP_REG_RD
  } op_e;

  typedef struct packed {
    op_e                   op;
    logic [31:0]           arg;   // length or beat count
    logic [REG_ADDR_W-1:0] addr;  // register index
    logic                  rdy;   // 0 inserts back-pressure
    int                    hold;  // stall cycles for commands
    logic [31:0]           exp;   // expected register value
  } row_t;

  logic                  pcie_clk;
  logic                  pcie_aresetn;
  logic                  wr_cmd_valid, rd_cmd_valid;
  dma_cmd_t              wr_cmd, rd_cmd;
  logic                  wr_cmd_ready, rd_cmd_ready;
  logic                  c2h_dsc_byp_ready, h2c_dsc_byp_ready;
  dsc_byp_t              c2h_dsc, h2c_dsc;
  logic                  wr_data_valid, wr_data_ready;
  axis_beat_t            wr_data, c2h_data, h2c_data, rd_data;
  logic                  c2h_valid, c2h_ready;
  logic                  h2c_valid, h2c_ready;
  logic                  rd_data_valid, rd_data_ready;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic                  reg_rd_en, reg_wr_en;
  logic [REG_DATA_W-1:0] reg_rd_data;
  logic                  reg_rd_valid;

  int err_cnt   = 0;
  int cycle_cnt = 0;
  int limit_cyc = 0;  // 0 until the table is loaded

  `include "dma_bypass_tb_table.svh"

  tb_clk_gen u_clk_gen (.pcie_clk(pcie_clk), .pcie_aresetn(pcie_aresetn));

  dma_bypass_top u_dut (.*);

  task automatic expect_true(input logic ok, input string msg);
    assert (ok) else begin
      err_cnt++;
      $display("[FAIL] %0t: %s", $time, msg);
    end
  endtask

  function automatic dsc_byp_t dsc_of(input logic rd);
    return rd ? h2c_dsc : c2h_dsc;
  endfunction

  function automatic logic cmd_ready_of(input logic rd);
    return rd ? rd_cmd_ready : wr_cmd_ready;
  endfunction

  task automatic drive_cmd(input logic rd, input logic v, input dma_cmd_t c, input logic byp);
    if (rd) begin
      rd_cmd_valid      = v;
      rd_cmd            = c;
      h2c_dsc_byp_ready = byp;
    end else begin
      wr_cmd_valid      = v;
      wr_cmd            = c;
      c2h_dsc_byp_ready = byp;
    end
  endtask

  // command with optional bypass stall and then one load carrying the held command
  task automatic send_cmd(input logic rd, input logic [LEN_W-1:0] len, input logic rdy,
                          input int hold);
    dma_cmd_t c;
    dsc_byp_t d;
    int       stall;
    int       k;
    c.addr = {$urandom, $urandom};
    c.len  = len;
    stall  = rdy ? 0 : hold;
    @(negedge pcie_clk);
    drive_cmd(rd, 1'b1, c, rdy);
    for (k = 0; k < stall; k++) begin
      @(posedge pcie_clk);
      expect_true(cmd_ready_of(rd) == 1'b0, "command ready high while bypass is stalled");
      @(negedge pcie_clk);
      d = dsc_of(rd);
      expect_true(d.load == 1'b0, "descriptor load while bypass is stalled");
    end
    drive_cmd(rd, 1'b1, c, 1'b1);
    @(posedge pcie_clk);  // acceptance edge
    expect_true(cmd_ready_of(rd) == 1'b1, "command ready low with bypass ready high");
    @(negedge pcie_clk);
    drive_cmd(rd, 1'b0, c, 1'b1);
    d = dsc_of(rd);
    expect_true(d.load == 1'b1, "no descriptor load one cycle after acceptance");
    expect_true(d.addr == c.addr && d.len == c.len,
                $sformatf("descriptor 0x%h/0x%h, expected 0x%h/0x%h",
                          d.addr, d.len, c.addr, c.len));
    @(negedge pcie_clk);
    d = dsc_of(rd);
    expect_true(d.load == 1'b0, "descriptor load longer than one cycle");
    expect_true(d.addr == c.addr && d.len == c.len, "descriptor not held after load");
  endtask

  function automatic axis_beat_t random_beat(input logic last);
    axis_beat_t b;
    int         j;
    for (j = 0; j < DATA_W / 32; j++) begin
      b.data[j*32 +: 32] = $urandom;
    end
    b.keep = {$urandom, $urandom};
    b.last = last;
    return b;
  endfunction

  task automatic drive_beat(input logic h2c, input logic v, input axis_beat_t b,
                            input logic sink_rdy);
    if (h2c) begin
      h2c_valid     = v;
      h2c_data      = b;
      rd_data_ready = sink_rdy;
    end else begin
      wr_data_valid = v;
      wr_data       = b;
      c2h_ready     = sink_rdy;
    end
  endtask

  task automatic check_beat(input logic h2c, input axis_beat_t b, input logic rdy);
    if (h2c) begin
      expect_true(rd_data_valid == 1'b1, "h2c valid not passed to rd_data");
      expect_true(rd_data == b, "rd_data differs from the h2c beat");
      expect_true(h2c_ready == rdy, "h2c_ready does not follow rd_data_ready");
    end else begin
      expect_true(c2h_valid == 1'b1, "wr_data valid not passed to c2h");
      expect_true(c2h_data == b, "c2h_data differs from the wr_data beat");
      expect_true(wr_data_ready == rdy, "wr_data_ready does not follow c2h_ready");
    end
  endtask

  // burst of n beats with last on the final one and the first beat stalled when rdy is 0
  task automatic send_beats(input logic h2c, input int n, input logic rdy);
    axis_beat_t b;
    int         i;
    for (i = 0; i < n; i++) begin
      b = random_beat(i == n - 1);
      @(negedge pcie_clk);
      drive_beat(h2c, 1'b1, b, !(i == 0 && !rdy));
      if (i == 0 && !rdy) begin
        @(posedge pcie_clk);
        check_beat(h2c, b, 1'b0);  // stalled beat must not count
        @(negedge pcie_clk);
        drive_beat(h2c, 1'b1, b, 1'b1);
      end
      @(posedge pcie_clk);
      check_beat(h2c, b, 1'b1);
    end
    @(negedge pcie_clk);
    drive_beat(h2c, 1'b0, b, 1'b1);
    @(posedge pcie_clk);
    if (h2c) begin
      expect_true(rd_data_valid == 1'b0, "rd_data valid high with h2c valid low");
    end else begin
      expect_true(c2h_valid == 1'b0, "c2h valid high with wr_data valid low");
    end
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] exp);
    @(negedge pcie_clk);
    reg_addr  = addr;
    reg_rd_en = 1'b1;
    @(negedge pcie_clk);
    reg_rd_en = 1'b0;
    expect_true(reg_rd_valid == 1'b1, "reg_rd_valid missing one cycle after the strobe");
    expect_true(reg_rd_data == exp, $sformatf("register %0d read 0x%08h, expected 0x%08h",
                                              addr, reg_rd_data, exp));
    @(negedge pcie_clk);
    expect_true(reg_rd_valid == 1'b0, "reg_rd_valid high for more than one cycle");
  endtask

  task automatic clear_len(input logic [REG_ADDR_W-1:0] addr);
    @(negedge pcie_clk);
    reg_addr  = addr;
    reg_wr_en = 1'b1;
    @(negedge pcie_clk);
    reg_wr_en = 1'b0;
    @(negedge pcie_clk);  // clear pulse has landed
  endtask

  function automatic int row_cycles(input row_t r);
    case (r.op)
      OP_WR_CMD, OP_RD_CMD:       return 3 + r.hold;
      OP_C2H_BEATS, OP_H2C_BEATS: return int'(r.arg) + 3;
      default:                    return 3;
    endcase
  endfunction

  // run limit
  always @(posedge pcie_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit_cyc != 0 && cycle_cnt >= limit_cyc) begin
      $display("timeout: run went past %0d cycles", limit_cyc);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin : main
    row_t r;
    int   i;
    int   errs_before;
    int   total;
    int   rows_ok;
    void'($urandom(32'h7fee869d));
    drive_cmd(1'b0, 1'b0, '0, 1'b1);
    drive_cmd(1'b1, 1'b0, '0, 1'b1);
    drive_beat(1'b0, 1'b0, '0, 1'b1);
    drive_beat(1'b1, 1'b0, '0, 1'b1);
    reg_addr  = '0;
    reg_rd_en = 1'b0;
    reg_wr_en = 1'b0;
    fill_table();
    total   = 0;
    rows_ok = 0;
    for (i = 0; i < N_ROWS; i++) begin
      total += row_cycles(rows[i]);
    end
    limit_cyc = 4 * total;
    wait (pcie_aresetn === 1'b1);
    @(negedge pcie_clk);
    expect_true(c2h_dsc.load == 1'b0 && h2c_dsc.load == 1'b0, "load strobe high after reset");
    expect_true(reg_rd_valid == 1'b0, "reg_rd_valid high after reset");
    for (i = 0; i < N_ROWS; i++) begin
      r           = rows[i];
      errs_before = err_cnt;
      case (r.op)
        OP_WR_CMD:    send_cmd(1'b0, r.arg, r.rdy, r.hold);
        OP_RD_CMD:    send_cmd(1'b1, r.arg, r.rdy, r.hold);
        OP_C2H_BEATS: send_beats(1'b0, int'(r.arg), r.rdy);
        OP_H2C_BEATS: send_beats(1'b1, int'(r.arg), r.rdy);
        OP_REG_CLR:   clear_len(r.addr);
        OP_REG_RD:    read_reg(r.addr, r.exp);
        default:      expect_true(1'b0, "unknown operation in the table");
      endcase
      if (err_cnt == errs_before) begin
        rows_ok++;
        $display("test %0d %s: ok", i, r.op.name());
      end else begin
        $display("test %0d %s: FAILED", i, r.op.name());
      end
    end
    $display("%0d tests, %0d ok, %0d failed, %0d check errors",
             N_ROWS, rows_ok, N_ROWS - rows_ok, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset
// Makes pcie_clk with period 8 and holds pcie_aresetn low for 4 cycles
`default_nettype none

module tb_clk_gen (
  output logic pcie_clk,
  output logic pcie_aresetn
);

  initial begin
    pcie_clk     = 1'b0;
    pcie_aresetn = 1'b0;              // in reset from time zero
    repeat (4) @(negedge pcie_clk);   // four rising edges in reset
    pcie_aresetn = 1'b1;              // released away from the rising edge
  end

  always #4 pcie_clk = ~pcie_clk;     // period 8

endmodule

`default_nettype wire

// ==== hdl/dma_bypass_top.sv ====
// DMA descriptor bypass front end
// Turns write and read commands into c2h and h2c bypass descriptors, passes
// the data streams through unchanged and keeps per-direction statistics
// behind a small register port. Runs on pcie_clk only.
`default_nettype none

module dma_bypass_top import dma_pkg::*; (
  input  logic                  pcie_clk,
  input  logic                  pcie_aresetn,

  // user commands
  input  logic                  wr_cmd_valid,
  input  dma_cmd_t              wr_cmd,
  output logic                  wr_cmd_ready,
  input  logic                  rd_cmd_valid,
  input  dma_cmd_t              rd_cmd,
  output logic                  rd_cmd_ready,

  // engine descriptor bypass
  input  logic                  c2h_dsc_byp_ready,
  output dsc_byp_t              c2h_dsc,
  input  logic                  h2c_dsc_byp_ready,
  output dsc_byp_t              h2c_dsc,

  // write data, user to engine
  input  logic                  wr_data_valid,
  input  axis_beat_t            wr_data,
  output logic                  wr_data_ready,
  output logic                  c2h_valid,
  output axis_beat_t            c2h_data,
  input  logic                  c2h_ready,

  // read data, engine to user
  input  logic                  h2c_valid,
  input  axis_beat_t            h2c_data,
  output logic                  h2c_ready,
  output logic                  rd_data_valid,
  output axis_beat_t            rd_data,
  input  logic                  rd_data_ready,

  // statistics register port
  input  logic [REG_ADDR_W-1:0] reg_addr,
  input  logic                  reg_rd_en,
  input  logic                  reg_wr_en,
  output logic [REG_DATA_W-1:0] reg_rd_data,
  output logic                  reg_rd_valid
);

  chan_stats_t wr_stats;    // c2h direction
  chan_stats_t rd_stats;    // h2c direction
  logic        wr_len_clr;
  logic        rd_len_clr;

  // stream pass-through, zero latency
  assign c2h_valid     = wr_data_valid;
  assign c2h_data      = wr_data;
  assign wr_data_ready = c2h_ready;
  assign rd_data_valid = h2c_valid;
  assign rd_data       = h2c_data;
  assign h2c_ready     = rd_data_ready;

  dsc_bypass u_c2h_byp (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_valid    (wr_cmd_valid),
    .cmd          (wr_cmd),
    .cmd_ready    (wr_cmd_ready),
    .byp_ready    (c2h_dsc_byp_ready),
    .dsc          (c2h_dsc)
  );

  dsc_bypass u_h2c_byp (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_valid    (rd_cmd_valid),
    .cmd          (rd_cmd),
    .cmd_ready    (rd_cmd_ready),
    .byp_ready    (h2c_dsc_byp_ready),
    .dsc          (h2c_dsc)
  );

  // stats watch the engine side of each stream
  dma_chan_stats u_wr_stats (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .dsc          (c2h_dsc),
    .beat_valid   (c2h_valid),
    .beat_ready   (c2h_ready),
    .beat_last    (c2h_data.last),
    .len_clr      (wr_len_clr),
    .stats        (wr_stats)
  );

  dma_chan_stats u_rd_stats (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .dsc          (h2c_dsc),
    .beat_valid   (h2c_valid),
    .beat_ready   (h2c_ready),
    .beat_last    (h2c_data.last),
    .len_clr      (rd_len_clr),
    .stats        (rd_stats)
  );

  dma_stat_regs u_regs (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .reg_addr     (reg_addr),
    .reg_rd_en    (reg_rd_en),
    .reg_wr_en    (reg_wr_en),
    .reg_rd_data  (reg_rd_data),
    .reg_rd_valid (reg_rd_valid),
    .wr_stats     (wr_stats),
    .rd_stats     (rd_stats),
    .wr_len_clr   (wr_len_clr),
    .rd_len_clr   (rd_len_clr)
  );

endmodule

`default_nettype wire

// ==== hdl/dma_chan_stats.sv ====
// DMA channel statistics
// Counts descriptor loads and accumulates their lengths into a 48-bit sum
// that software can clear. Also counts stream words and packets as seen on
// the engine side of one direction.
`default_nettype none

module dma_chan_stats import dma_pkg::*; (
  input  logic        pcie_clk,
  input  logic        pcie_aresetn,

  input  dsc_byp_t    dsc,         // descriptor toward the engine
  input  logic        beat_valid,
  input  logic        beat_ready,
  input  logic        beat_last,

  input  logic        len_clr,     // one-cycle clear of len_sum
  output chan_stats_t stats
);

  logic              beat_xfer;  // word moves this cycle
  logic [LSUM_W-1:0] len_ext;    // loaded length widened to the sum

  assign beat_xfer = beat_valid & beat_ready;
  assign len_ext   = {{(LSUM_W-LEN_W){1'b0}}, dsc.len};

  // command counter
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      stats.cmds <= '0;
    end else if (dsc.load) begin
      stats.cmds <= stats.cmds + 1'b1;
    end
  end

  // length sum, clear wins over a load in the same cycle
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      stats.len_sum <= '0;
    end else if (len_clr) begin
      stats.len_sum <= '0;
    end else if (dsc.load) begin
      stats.len_sum <= stats.len_sum + len_ext;
    end
  end

  // word counter, stalled beats not counted
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      stats.words <= '0;
    end else if (beat_xfer) begin
      stats.words <= stats.words + 1'b1;
    end
  end

  // packet counter, one per last beat
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      stats.pkgs <= '0;
    end else if (beat_xfer && beat_last) begin
      stats.pkgs <= stats.pkgs + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
// DMA bypass package
// Holds the widths, the statistics register map and the packed structs
// shared by the descriptor bypass, statistics and register blocks.
`default_nettype none

package dma_pkg;

  localparam int ADDR_W     = 64;  // host address
  localparam int LEN_W      = 32;  // command length in bytes
  localparam int DATA_W     = 512; // stream word
  localparam int KEEP_W     = DATA_W / 8;
  localparam int CNT_W      = 32;  // event counters
  localparam int LSUM_W     = 48;  // length accumulator
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;

  // statistics register map, word index
  localparam logic [REG_ADDR_W-1:0] REG_WR_CMDS   = 4'd0;
  localparam logic [REG_ADDR_W-1:0] REG_WR_LEN_LO = 4'd1;  // write clears wr sum
  localparam logic [REG_ADDR_W-1:0] REG_WR_LEN_HI = 4'd2;
  localparam logic [REG_ADDR_W-1:0] REG_WR_WORDS  = 4'd3;
  localparam logic [REG_ADDR_W-1:0] REG_WR_PKGS   = 4'd4;
  localparam logic [REG_ADDR_W-1:0] REG_RD_CMDS   = 4'd5;
  localparam logic [REG_ADDR_W-1:0] REG_RD_LEN_LO = 4'd6;  // write clears rd sum
  localparam logic [REG_ADDR_W-1:0] REG_RD_LEN_HI = 4'd7;
  localparam logic [REG_ADDR_W-1:0] REG_RD_WORDS  = 4'd8;
  localparam logic [REG_ADDR_W-1:0] REG_RD_PKGS   = 4'd9;
  localparam logic [REG_ADDR_W-1:0] REG_FLUSHED   = 4'd10; // bit 0 only

  // command word, len in the upper bits as on the user side
  typedef struct packed {
    logic [LEN_W-1:0]  len;
    logic [ADDR_W-1:0] addr;
  } dma_cmd_t;

  // descriptor bypass port toward the engine
  typedef struct packed {
    logic              load;  // one-cycle strobe
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } dsc_byp_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
  } axis_beat_t;

  // statistics of one direction
  typedef struct packed {
    logic [CNT_W-1:0]  cmds;
    logic [LSUM_W-1:0] len_sum;
    logic [CNT_W-1:0]  words;
    logic [CNT_W-1:0]  pkgs;
  } chan_stats_t;

endpackage

`default_nettype wire

// ==== hdl/dma_stat_regs.sv ====
// DMA statistics register block
// Decodes the strobe register port. Reads return a counter one cycle after
// the strobe, writes to a length-low register clear that length sum. Also
// keeps the reads-flushed flag.
`default_nettype none

module dma_stat_regs import dma_pkg::*; (
  input  logic                  pcie_clk,
  input  logic                  pcie_aresetn,

  input  logic [REG_ADDR_W-1:0] reg_addr,
  input  logic                  reg_rd_en,
  input  logic                  reg_wr_en,   // data ignored, address acts
  output logic [REG_DATA_W-1:0] reg_rd_data,
  output logic                  reg_rd_valid,

  input  chan_stats_t           wr_stats,
  input  chan_stats_t           rd_stats,
  output logic                  wr_len_clr,
  output logic                  rd_len_clr
);

  localparam int HI_W = LSUM_W - REG_DATA_W; // bits in the len_hi registers

  logic [REG_DATA_W-1:0] rd_word;  // selected register
  logic                  flushed;  // all read commands have returned

  // read select
  always_comb begin
    case (reg_addr)
      REG_WR_CMDS:   rd_word = wr_stats.cmds;
      REG_WR_LEN_LO: rd_word = wr_stats.len_sum[REG_DATA_W-1:0];
      REG_WR_LEN_HI: rd_word = {{(REG_DATA_W-HI_W){1'b0}},
                               wr_stats.len_sum[LSUM_W-1:REG_DATA_W]};
      REG_WR_WORDS:  rd_word = wr_stats.words;
      REG_WR_PKGS:   rd_word = wr_stats.pkgs;
      REG_RD_CMDS:   rd_word = rd_stats.cmds;
      REG_RD_LEN_LO: rd_word = rd_stats.len_sum[REG_DATA_W-1:0];
      REG_RD_LEN_HI: rd_word = {{(REG_DATA_W-HI_W){1'b0}},
                               rd_stats.len_sum[LSUM_W-1:REG_DATA_W]};
      REG_RD_WORDS:  rd_word = rd_stats.words;
      REG_RD_PKGS:   rd_word = rd_stats.pkgs;
      REG_FLUSHED:   rd_word = {{(REG_DATA_W-1){1'b0}}, flushed};
      default:       rd_word = '0;          // unmapped reads as zero
    endcase
  end

  // read response, one cycle after the strobe
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      reg_rd_valid <= 1'b0;
    end else begin
      reg_rd_valid <= reg_rd_en;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (reg_rd_en) begin
      reg_rd_data <= rd_word;              // held until the next read
    end
  end

  // clear pulses and flushed flag
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      wr_len_clr <= 1'b0;
      rd_len_clr <= 1'b0;
      flushed    <= 1'b0;
    end else begin
      wr_len_clr <= reg_wr_en && (reg_addr == REG_WR_LEN_LO);
      rd_len_clr <= reg_wr_en && (reg_addr == REG_RD_LEN_LO);
      flushed    <= (rd_stats.cmds == rd_stats.pkgs); // re-evaluated each cycle
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dsc_bypass.sv ====
// Descriptor bypass channel
// Registers an accepted command into the engine's bypass descriptor and
// raises load for one cycle. Bypass ready goes straight back to the
// command source so the engine can stall it.
`default_nettype none

module dsc_bypass import dma_pkg::*; (
  input  logic     pcie_clk,
  input  logic     pcie_aresetn,

  input  logic     cmd_valid,
  input  dma_cmd_t cmd,
  output logic     cmd_ready,

  input  logic     byp_ready,  // engine can take a descriptor
  output dsc_byp_t dsc
);

  logic cmd_acc; // command handshake this cycle

  assign cmd_ready = byp_ready;             // no buffering, engine stalls source
  assign cmd_acc   = cmd_valid & cmd_ready;

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      dsc.load <= 1'b0;
    end else begin
      dsc.load <= cmd_acc;                  // high for one cycle per command
    end
  end

  // descriptor payload, holds until the next command
  always_ff @(posedge pcie_clk) begin
    if (cmd_acc) begin
      dsc.addr <= cmd.addr;
      dsc.len  <= cmd.len;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DMA bypass testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module dma_bypass_tb \
  -Mdir "$BUILD_DIR" \
  -f all.f

"./$BUILD_DIR/Vdma_bypass_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Testbench passed" "$LOG"; then
  echo "simulation result: PASS"
  exit 0
fi

echo "simulation result: FAIL"
exit 1
